//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // opcode fields, matched against the top bits of the instruction word
    localparam logic [16:0] op_add_w   = 17'h00020;
    localparam logic [16:0] op_sub_w   = 17'h00022;
    localparam logic [16:0] op_and     = 17'h00029;
    localparam logic [16:0] op_or      = 17'h0002a;
    localparam logic [9:0]  op_addi_w  = 10'h00a;
    localparam logic [9:0]  op_ld_w    = 10'h0a2;
    localparam logic [9:0]  op_st_w    = 10'h0a6;
    localparam logic [6:0]  op_lu12i_w = 7'h0a;
    localparam logic [5:0]  op_beq     = 6'h16;
    localparam logic [5:0]  op_bne     = 6'h17;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fs_ds_bus_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_t               alu_op;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [xlen-1:0]       st_data;
        logic [reg_addr_w-1:0] dest;
        logic                  rf_we;
        logic                  mem_re;
        logic                  mem_we;
    } ds_es_bus_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] dest;
        logic                  rf_we;
        logic                  mem_re;
    } es_ms_bus_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       value;
        logic [reg_addr_w-1:0] dest;
        logic                  rf_we;
    } ms_ws_bus_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_bus_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_bus_t;

endpackage

`default_nettype wire

//--- logic/sram_if.sv
`timescale 1ns/1ps
`default_nettype none

// one synchronous SRAM port, rdata valid the cycle after en
interface sram_if;

    logic        en;
    logic [3:0]  we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;

    modport host (output en, output we, output addr, output wdata, input rdata);
    modport sram (input en, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] reset_pc = 32'h1c000000
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cpu_pkg::br_bus_t br,
    input  wire                   ds_allowin,
    output logic                  fs_to_ds_valid,
    output cpu_pkg::fs_ds_bus_t   fs_to_ds_bus,
    sram_if.host                  inst_sram
);

    logic                     fs_valid;
    logic                     fs_allowin;
    logic [cpu_pkg::xlen-1:0] fs_pc;
    logic [cpu_pkg::xlen-1:0] nextpc;
    logic                     rdata_live;
    logic [cpu_pkg::xlen-1:0] inst_hold;

    assign fs_allowin = !fs_valid || ds_allowin;
    assign nextpc     = br.taken ? br.target : fs_pc + 32'd4;

    // the word behind a taken branch is dropped here
    assign fs_to_ds_valid = fs_valid && !br.taken;

    // request only when the current word can move on
    assign inst_sram.en    = fs_allowin;
    assign inst_sram.we    = 4'b0;
    assign inst_sram.addr  = nextpc;
    assign inst_sram.wdata = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fs_valid   <= 1'b0;
            // first increment lands on reset_pc
            fs_pc      <= reset_pc - 32'd4;
            rdata_live <= 1'b0;
        end else begin
            rdata_live <= inst_sram.en;
            if (fs_allowin) begin
                fs_valid <= 1'b1;
                fs_pc    <= nextpc;
            end
        end
    end

    // keep the returned word while decode is stalled
    always_ff @(posedge clk) begin
        if (rdata_live) begin
            inst_hold <= inst_sram.rdata;
        end
    end

    assign fs_to_ds_bus.pc   = fs_pc;
    assign fs_to_ds_bus.inst = rdata_live ? inst_sram.rdata : inst_hold;

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            fs_to_ds_valid,
    input  wire cpu_pkg::fs_ds_bus_t       fs_to_ds_bus,
    input  wire                            es_allowin,
    input  wire                            ds_stall,
    output logic                           ds_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] ds_src1,
    output logic [cpu_pkg::reg_addr_w-1:0] ds_src2,
    output logic                           ds_to_es_valid,
    output cpu_pkg::ds_es_bus_t            ds_to_es_bus,
    output cpu_pkg::br_bus_t               br,
    input  wire cpu_pkg::rf_bus_t          rf
);

    cpu_pkg::fs_ds_bus_t      ds_bus;
    logic                     ds_leave;
    logic [31:0]              inst;
    logic [4:0]               rd;
    logic                     is_add, is_sub, is_and, is_or, is_addi;
    logic                     is_lu12i, is_ld, is_st, is_beq, is_bne;
    logic                     reg_reg;
    logic [cpu_pkg::xlen-1:0] src1_val;
    logic [cpu_pkg::xlen-1:0] src2_val;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] regs [32];

    assign ds_to_es_valid = ds_valid && !ds_stall;
    assign ds_leave       = ds_to_es_valid && es_allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (!ds_valid || ds_leave) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if ((!ds_valid || ds_leave) && fs_to_ds_valid) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    // writeback never targets r0
    always_ff @(posedge clk) begin
        if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    assign inst     = ds_bus.inst;
    assign rd       = inst[4:0];
    assign is_add   = inst[31:15] == cpu_pkg::op_add_w;
    assign is_sub   = inst[31:15] == cpu_pkg::op_sub_w;
    assign is_and   = inst[31:15] == cpu_pkg::op_and;
    assign is_or    = inst[31:15] == cpu_pkg::op_or;
    assign is_addi  = inst[31:22] == cpu_pkg::op_addi_w;
    assign is_ld    = inst[31:22] == cpu_pkg::op_ld_w;
    assign is_st    = inst[31:22] == cpu_pkg::op_st_w;
    assign is_lu12i = inst[31:25] == cpu_pkg::op_lu12i_w;
    assign is_beq   = inst[31:26] == cpu_pkg::op_beq;
    assign is_bne   = inst[31:26] == cpu_pkg::op_bne;
    assign reg_reg  = is_add || is_sub || is_and || is_or;

    // unused source slots read r0 so they never cause a stall
    assign ds_src1 = is_lu12i ? '0 : inst[9:5];
    assign ds_src2 = reg_reg ? inst[14:10] : (is_st || is_beq || is_bne) ? rd : '0;

    assign src1_val = (ds_src1 == '0) ? '0 : regs[ds_src1];
    assign src2_val = (ds_src2 == '0) ? '0 : regs[ds_src2];

    assign imm = is_lu12i ? {inst[24:5], 12'b0} : {{20{inst[21]}}, inst[21:10]};

    assign br.taken  = ds_leave && ((is_beq && src1_val == src2_val) ||
                                    (is_bne && src1_val != src2_val));
    assign br.target = ds_bus.pc + {{14{inst[25]}}, inst[25:10], 2'b00};

    assign ds_to_es_bus.pc      = ds_bus.pc;
    assign ds_to_es_bus.alu_op  = is_sub   ? cpu_pkg::alu_sub :
                                  is_and   ? cpu_pkg::alu_and :
                                  is_or    ? cpu_pkg::alu_or  :
                                  is_lu12i ? cpu_pkg::alu_lui : cpu_pkg::alu_add;
    assign ds_to_es_bus.src_a   = src1_val;
    assign ds_to_es_bus.src_b   = reg_reg ? src2_val : imm;
    assign ds_to_es_bus.st_data = src2_val;
    assign ds_to_es_bus.dest    = rd;
    // writes to r0 are dropped at the source
    assign ds_to_es_bus.rf_we   = (reg_reg || is_addi || is_lu12i || is_ld) && rd != '0;
    assign ds_to_es_bus.mem_re  = is_ld;
    assign ds_to_es_bus.mem_we  = is_st;

endmodule

`default_nettype wire

//--- logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            ds_to_es_valid,
    input  wire cpu_pkg::ds_es_bus_t       ds_to_es_bus,
    input  wire                            ms_allowin,
    input  wire                            es_allowin,
    output logic                           es_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] es_dest,
    output logic                           es_rf_we,
    output logic                           es_to_ms_valid,
    output cpu_pkg::es_ms_bus_t            es_to_ms_bus,
    sram_if.host                           data_sram
);

    cpu_pkg::ds_es_bus_t      es_bus;
    logic [cpu_pkg::xlen-1:0] result;
    logic                     es_leave;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_allowin && ds_to_es_valid) begin
            es_bus <= ds_to_es_bus;
        end
    end

    // loads and stores reuse the adder for the address
    always_comb begin
        case (es_bus.alu_op)
            cpu_pkg::alu_sub: result = es_bus.src_a - es_bus.src_b;
            cpu_pkg::alu_and: result = es_bus.src_a & es_bus.src_b;
            cpu_pkg::alu_or:  result = es_bus.src_a | es_bus.src_b;
            cpu_pkg::alu_lui: result = es_bus.src_b;
            default:          result = es_bus.src_a + es_bus.src_b;
        endcase
    end

    assign es_dest        = es_bus.dest;
    assign es_rf_we       = es_bus.rf_we;
    assign es_to_ms_valid = es_valid;
    assign es_leave       = es_valid && ms_allowin;

    assign es_to_ms_bus.pc     = es_bus.pc;
    assign es_to_ms_bus.result = result;
    assign es_to_ms_bus.dest   = es_bus.dest;
    assign es_to_ms_bus.rf_we  = es_bus.rf_we;
    assign es_to_ms_bus.mem_re = es_bus.mem_re;

    // request goes out as the instruction enters memory
    assign data_sram.en    = es_leave && (es_bus.mem_re || es_bus.mem_we);
    assign data_sram.we    = {4{es_leave && es_bus.mem_we}};
    assign data_sram.addr  = result;
    assign data_sram.wdata = es_bus.st_data;

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            es_to_ms_valid,
    input  wire cpu_pkg::es_ms_bus_t       es_to_ms_bus,
    input  wire                            ws_allowin,
    output logic                           ms_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] ms_dest,
    output logic                           ms_rf_we,
    output logic                           ms_to_ws_valid,
    output cpu_pkg::ms_ws_bus_t            ms_to_ws_bus,
    input  wire [cpu_pkg::xlen-1:0]        data_rdata
);

    cpu_pkg::es_ms_bus_t ms_bus;
    logic                ms_take;

    assign ms_take = !ms_valid || ws_allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_take) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_take && es_to_ms_valid) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    assign ms_dest        = ms_bus.dest;
    assign ms_rf_we       = ms_bus.rf_we;
    assign ms_to_ws_valid = ms_valid;

    // load data arrives while the load sits in this stage
    assign ms_to_ws_bus.pc    = ms_bus.pc;
    assign ms_to_ws_bus.value = ms_bus.mem_re ? data_rdata : ms_bus.result;
    assign ms_to_ws_bus.dest  = ms_bus.dest;
    assign ms_to_ws_bus.rf_we = ms_bus.rf_we;

endmodule

`default_nettype wire

//--- logic/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            ms_to_ws_valid,
    input  wire cpu_pkg::ms_ws_bus_t       ms_to_ws_bus,
    output logic                           ws_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] ws_dest,
    output logic                           ws_rf_we,
    output cpu_pkg::rf_bus_t               rf,
    output logic [31:0]                    debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_we,
    output logic [4:0]                     debug_wb_rf_wnum,
    output logic [31:0]                    debug_wb_rf_wdata
);

    cpu_pkg::ms_ws_bus_t ws_bus;

    // retires every cycle, so always ready to take the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign ws_dest  = ws_bus.dest;
    assign ws_rf_we = ws_bus.rf_we;

    assign rf.we    = ws_valid && ws_bus.rf_we;
    assign rf.waddr = ws_bus.dest;
    assign rf.wdata = ws_bus.value;

    // r0 writes never reach here, decode clears their rf_we
    assign debug_wb_pc       = ws_bus.pc;
    assign debug_wb_rf_we    = {4{rf.we}};
    assign debug_wb_rf_wnum  = ws_bus.dest;
    assign debug_wb_rf_wdata = ws_bus.value;

endmodule

`default_nettype wire

//--- logic/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input  wire                            ds_valid,
    input  wire [cpu_pkg::reg_addr_w-1:0]  ds_src1,
    input  wire [cpu_pkg::reg_addr_w-1:0]  ds_src2,
    input  wire                            es_valid,
    input  wire [cpu_pkg::reg_addr_w-1:0]  es_dest,
    input  wire                            es_rf_we,
    input  wire                            ms_valid,
    input  wire [cpu_pkg::reg_addr_w-1:0]  ms_dest,
    input  wire                            ms_rf_we,
    input  wire                            ws_valid,
    input  wire [cpu_pkg::reg_addr_w-1:0]  ws_dest,
    input  wire                            ws_rf_we,
    output logic                           ms_allowin,
    output logic                           ds_stall,
    output logic                           ds_allowin,
    output logic                           es_allowin
);

    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    // rf_we is never set for r0, so a zero source cannot match
    assign es_hit = es_valid && es_rf_we && (es_dest == ds_src1 || es_dest == ds_src2);
    assign ms_hit = ms_valid && ms_rf_we && (ms_dest == ds_src1 || ms_dest == ds_src2);
    assign ws_hit = ws_valid && ws_rf_we && (ws_dest == ds_src1 || ws_dest == ds_src2);

    // without forwarding decode waits until the producer has left writeback
    assign ds_stall = ds_valid && (es_hit || ms_hit || ws_hit);

    // writeback retires every cycle so memory never holds
    assign ms_allowin = 1'b1;
    assign es_allowin = !es_valid || ms_allowin;
    assign ds_allowin = !ds_valid || (!ds_stall && es_allowin);

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter logic [31:0] reset_pc = 32'h1c000000
) (
    input  wire         clk,
    input  wire         rst_n,
    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  wire  [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  wire  [31:0] data_sram_rdata,
    // retire trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                fs_to_ds_valid;
    logic                ds_to_es_valid;
    logic                es_to_ms_valid;
    logic                ms_to_ws_valid;
    logic                ds_allowin;
    logic                es_allowin;
    logic                ms_allowin;
    logic                ds_stall;
    logic                ds_valid;
    logic                es_valid;
    logic                ms_valid;
    logic                ws_valid;
    logic [4:0]          ds_src1;
    logic [4:0]          ds_src2;
    logic [4:0]          es_dest;
    logic [4:0]          ms_dest;
    logic [4:0]          ws_dest;
    logic                es_rf_we;
    logic                ms_rf_we;
    logic                ws_rf_we;
    cpu_pkg::fs_ds_bus_t fs_to_ds_bus;
    cpu_pkg::ds_es_bus_t ds_to_es_bus;
    cpu_pkg::es_ms_bus_t es_to_ms_bus;
    cpu_pkg::ms_ws_bus_t ms_to_ws_bus;
    cpu_pkg::rf_bus_t    rf;
    cpu_pkg::br_bus_t    br;

    sram_if inst_sram ();
    sram_if data_sram ();

    // break both sram ports out to plain pins
    assign inst_sram_en    = inst_sram.en;
    assign inst_sram_we    = inst_sram.we;
    assign inst_sram_addr  = inst_sram.addr;
    assign inst_sram_wdata = inst_sram.wdata;
    assign inst_sram.rdata = inst_sram_rdata;
    assign data_sram_en    = data_sram.en;
    assign data_sram_we    = data_sram.we;
    assign data_sram_addr  = data_sram.addr;
    assign data_sram_wdata = data_sram.wdata;
    assign data_sram.rdata = data_sram_rdata;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    exec_stage u_exec_stage (.*);

    // writeback takes a new instruction every cycle
    mem_stage u_mem_stage (
        .ws_allowin (1'b1),
        .data_rdata (data_sram.rdata),
        .*
    );

    wb_stage u_wb_stage (.*);

    hazard_ctrl u_hazard_ctrl (.*);

endmodule

`default_nettype wire

//--- test/cpu_tb_model.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// major opcodes of the kept LoongArch instructions
localparam logic [16:0] add_op   = 17'h00020;
localparam logic [16:0] sub_op   = 17'h00022;
localparam logic [16:0] and_op   = 17'h00029;
localparam logic [16:0] or_op    = 17'h0002a;
localparam logic [9:0]  addi_op  = 10'h00a;
localparam logic [9:0]  ld_op    = 10'h0a2;
localparam logic [9:0]  st_op    = 10'h0a6;
localparam logic [6:0]  lu12i_op = 7'h0a;
localparam logic [5:0]  beq_op   = 6'h16;
localparam logic [5:0]  bne_op   = 6'h17;

function automatic logic [31:0] reg3_inst(input logic [16:0] op, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
    return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] imm12_inst(input logic [9:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [11:0] si12);
    return {op, si12, rj, rd};
endfunction

function automatic logic [31:0] lu12i_inst(input logic [4:0] rd, input logic [19:0] si20);
    return {lu12i_op, si20, rd};
endfunction

// offs16 counts words from the branch itself
function automatic logic [31:0] branch_inst(input logic [5:0] op, input logic [4:0] rj,
                                            input logic [4:0] rd, input logic [15:0] offs16);
    return {op, offs16, rj, rd};
endfunction

// r0 writes leave no trace entry
task automatic write_reg(input int at, input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
        model_regs[rd] = value;
        exp_pc.push_back(reset_pc + 32'(at * 4));
        exp_num.push_back(rd);
        exp_data.push_back(value);
    end
endtask

// architectural run of the program up to the final self-loop
task automatic run_reference();
    int          idx;
    int          next_idx;
    int          steps;
    logic [31:0] w;
    logic [31:0] rj_val;
    logic [31:0] rk_val;
    logic [31:0] rd_val;
    logic [31:0] sum_imm;
    logic        taken;
    idx   = 0;
    steps = 0;
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = 32'h0;
    end
    for (int i = 0; i < 256; i++) begin
        model_mem[i] = fill_word(i);
    end
    while (idx != loop_idx && steps < max_steps) begin
        w        = prog[idx];
        rj_val   = model_regs[w[9:5]];
        rk_val   = model_regs[w[14:10]];
        rd_val   = model_regs[w[4:0]];
        sum_imm  = rj_val + {{20{w[21]}}, w[21:10]};
        next_idx = idx + 1;
        if (w[31:26] == beq_op || w[31:26] == bne_op) begin
            taken = (w[31:26] == beq_op) ? (rj_val == rd_val) : (rj_val != rd_val);
            if (taken) begin
                next_idx = idx + int'($signed(w[25:10]));
            end
        end else if (w[31:25] == lu12i_op) begin
            write_reg(idx, w[4:0], {w[24:5], 12'b0});
        end else if (w[31:22] == addi_op) begin
            write_reg(idx, w[4:0], sum_imm);
        end else if (w[31:22] == ld_op) begin
            write_reg(idx, w[4:0], model_mem[sum_imm[9:2]]);
        end else if (w[31:22] == st_op) begin
            model_mem[sum_imm[9:2]] = rd_val;
        end else begin
            case (w[31:15])
                add_op:  write_reg(idx, w[4:0], rj_val + rk_val);
                sub_op:  write_reg(idx, w[4:0], rj_val - rk_val);
                and_op:  write_reg(idx, w[4:0], rj_val & rk_val);
                default: write_reg(idx, w[4:0], rj_val | rk_val);
            endcase
        end
        idx   = next_idx;
        steps = steps + 1;
    end
    if (idx != loop_idx) begin
        abort_run("reference model did not reach the final self-loop");
    end
endtask

`endif

//--- test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int          clk_period = 20;
    localparam logic [31:0] reset_pc   = 32'h1c000000;
    localparam logic [31:0] data_base  = 32'h00001000;
    localparam int          first_rand = 31;
    localparam int          loop_idx   = first_rand + 200;
    localparam int          prog_len   = loop_idx + 1;
    localparam logic [31:0] loop_pc    = reset_pc + 32'(loop_idx * 4);
    localparam int          max_steps  = 10000;
    // self-loop fetches to wait for while older work drains
    localparam int          drain_hits = 5;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic [31:0] inst_word_q;
    logic [31:0] data_word_q;

    logic [31:0] rng_state = 32'd47943;
    logic [31:0] prog [256];
    logic [31:0] data_mem [256];
    logic [31:0] model_mem [256];
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    int          model_count;
    int          retired = 0;
    int          loop_hits = 0;

    cpu_top #(.reset_pc(reset_pc)) u_cpu_top (.*);

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int pick(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    // initial data memory contents that differ for every word
    function automatic logic [31:0] fill_word(input int i);
        return 32'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
    endfunction

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %08h expected %08h",
                     $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    `include "cpu_tb_model.svh"

    // register setup and base r31 ahead of the random body and the self-loop
    task automatic build_program();
        int          kind;
        int          span;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  last_rd;
        logic [11:0] off;
        last_rd = 5'd1;
        for (int i = 0; i < 256; i++) begin
            prog[i] = branch_inst(beq_op, 5'd0, 5'd0, 16'd0);
        end
        for (int r = 1; r < 31; r++) begin
            prog[r - 1] = imm12_inst(addi_op, 5'(r), 5'd0, 12'(next_random()));
        end
        prog[30] = lu12i_inst(5'd31, 20'h00001);
        for (int idx = first_rand; idx < loop_idx; idx++) begin
            kind = pick(10);
            rd   = 5'(pick(31));
            // half the time lean on the last result to provoke stalls
            rj   = pick(2) == 0 ? last_rd : 5'(pick(32));
            rk   = 5'(pick(32));
            off  = 12'(pick(256) * 4);
            span = loop_idx - idx;
            if (span > 5) begin
                span = 5;
            end
            case (kind)
                0: prog[idx] = reg3_inst(add_op, rd, rj, rk);
                1: prog[idx] = reg3_inst(sub_op, rd, rj, rk);
                2: prog[idx] = reg3_inst(and_op, rd, rj, rk);
                3: prog[idx] = reg3_inst(or_op, rd, rj, rk);
                4: prog[idx] = imm12_inst(addi_op, rd, rj, 12'(next_random()));
                5: prog[idx] = lu12i_inst(rd, 20'(next_random()));
                6: prog[idx] = imm12_inst(ld_op, rd, 5'd31, off);
                7: prog[idx] = imm12_inst(st_op, rk, 5'd31, off);
                8: prog[idx] = branch_inst(beq_op, rj, pick(4) == 0 ? rj : rk,
                                           16'(1 + pick(span)));
                default: prog[idx] = branch_inst(bne_op, rj, rk, 16'(1 + pick(span)));
            endcase
            if (kind < 7) begin
                last_rd = rd;
            end
        end
        prog[loop_idx] = branch_inst(beq_op, 5'd0, 5'd0, 16'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // read-only instruction sram with one cycle of read latency
    initial begin
        inst_sram_rdata = 32'h0;
        inst_word_q     = 32'h0;
        forever begin
            @(negedge clk);
            inst_sram_rdata <= inst_word_q;
            check_value(32'(inst_sram_we), 32'h0, "instruction sram write enable");
            if (inst_sram_en) begin
                inst_word_q <= prog[inst_sram_addr[9:2]];
            end
        end
    end

    // data sram where a write lands before any later read
    initial begin
        data_sram_rdata = 32'h0;
        data_word_q     = 32'h0;
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            data_sram_rdata <= data_word_q;
            if (data_sram_en) begin
                check_value({data_sram_addr[31:10], 10'b0}, data_base, "data address window");
                for (int b = 0; b < 4; b++) begin
                    if (data_sram_we[b]) begin
                        data_mem[data_sram_addr[9:2]][8*b +: 8] = data_sram_wdata[8*b +: 8];
                    end
                end
                data_word_q <= data_mem[data_sram_addr[9:2]];
            end
        end
    end

    // trace checker
    always @(negedge clk) begin
        if (retired == 0) begin
            check_value(32'(data_sram_we), 32'h0, "data write enable before first retire");
        end
        if (debug_wb_rf_we != 4'h0) begin
            if (exp_pc.size() == 0) begin
                abort_run("a register write retired after the expected trace ran out");
            end else begin
                check_value(32'(debug_wb_rf_we), 32'hf, "trace write enable");
                check_value(debug_wb_pc, exp_pc.pop_front(), "trace pc");
                check_value(32'(debug_wb_rf_wnum), 32'(exp_num.pop_front()), "trace wnum");
                check_value(debug_wb_rf_wdata, exp_data.pop_front(), "trace wdata");
                retired = retired + 1;
            end
        end
        if (inst_sram_en && inst_sram_addr == loop_pc) begin
            loop_hits = loop_hits + 1;
        end
    end

    initial begin
        #(prog_len * 8 * clk_period);
        abort_run("program never reached its final self-loop before the watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        run_reference();
        model_count = exp_pc.size();
        repeat (3) begin
            @(negedge clk);
            check_value(32'(debug_wb_rf_we), 32'h0, "trace write enable in reset");
            check_value(32'(data_sram_we), 32'h0, "data write enable in reset");
        end
        rst_n = 1'b1;
        // fetch came out of reset already requesting
        check_value(32'(inst_sram_en), 32'h1, "first fetch enable");
        check_value(inst_sram_addr, reset_pc, "first fetch address");
        wait (loop_hits >= drain_hits);
        @(negedge clk);
        check_value(32'(retired), 32'(model_count), "trace event count");
        for (int i = 0; i < 256; i++) begin
            check_value(data_mem[i], model_mem[i], $sformatf("final data word %0d", i));
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
logic/cpu_pkg.sv
logic/sram_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/hazard_ctrl.sv
logic/cpu_top.sv
test/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log

.PHONY: sim clean

# the simulation passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
